/* verilog/vu_pkg.sv */
// ========================================
// shared widths, unit and opcode encodings
// for the vector execution cluster
// ========================================

`default_nettype none

package vu_pkg;

    // operand and result element width
    localparam int unsigned DATA_W = 32;

    // instruction id and destination vector register address
    localparam int unsigned ID_W    = 3;
    localparam int unsigned VADDR_W = 5;

    // element count field holds count minus one
    localparam int unsigned ELEM_W = 3;

    // load/store data memory
    localparam int unsigned MEM_ADDR_W = 4;
    localparam int unsigned MEM_DEPTH  = 16;

    // instruction queue in front of the load/store unit
    localparam int unsigned LSU_QUEUE_DEPTH = 2;

    typedef enum logic {
        UNIT_ALU,
        UNIT_LSU
    } unit_e;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_LOAD,
        OP_STORE
    } op_e;

endpackage

`default_nettype wire

/* verilog/vu_alu_unit.sv */
// ========================================
// arithmetic unit, holds one instruction and
// streams one result element per cycle
// ========================================

`timescale 1ns/1ps
`default_nettype none

module vu_alu_unit (
    input  logic                        clk_i,
    input  logic                        async_rst_ni,

    input  logic                        in_valid_i,
    output logic                        in_ready_o,
    input  vu_pkg::op_e                 in_op_i,
    input  logic [vu_pkg::ID_W-1:0]     in_id_i,
    input  logic [vu_pkg::VADDR_W-1:0]  in_vaddr_i,
    input  logic [vu_pkg::ELEM_W-1:0]   in_elems_i,
    input  logic [vu_pkg::DATA_W-1:0]   in_opa_i,
    input  logic [vu_pkg::DATA_W-1:0]   in_opb_i,

    output logic                        out_valid_o,
    input  logic                        out_ready_i,
    output logic [vu_pkg::ID_W-1:0]     out_id_o,
    output logic [vu_pkg::VADDR_W-1:0]  out_vaddr_o,
    output logic [vu_pkg::DATA_W-1:0]   out_data_o,
    output logic                        out_done_o
);
    import vu_pkg::*;

    logic               busy_q;
    logic [ELEM_W-1:0]  cnt_q;
    op_e                op_q;
    logic [ID_W-1:0]    id_q;
    logic [VADDR_W-1:0] vaddr_q;
    logic [ELEM_W-1:0]  elems_q;
    logic [DATA_W-1:0]  opa_q;
    logic [DATA_W-1:0]  opb_q;
    logic [DATA_W-1:0]  elem_a;
    logic               accept;
    logic               xfer;

    assign out_valid_o = busy_q;
    assign out_done_o  = busy_q && (cnt_q == elems_q);
    assign out_id_o    = id_q;
    assign out_vaddr_o = vaddr_q;

    assign xfer       = busy_q && out_ready_i;
    // free again in the cycle the last element leaves
    assign in_ready_o = !busy_q || (xfer && out_done_o);
    assign accept     = in_valid_i && in_ready_o;

    // first operand advances with the element index
    assign elem_a = opa_q + DATA_W'(cnt_q);

    always_comb begin
        case (op_q)
            OP_ADD:  out_data_o = elem_a + opb_q;
            OP_SUB:  out_data_o = elem_a - opb_q;
            OP_AND:  out_data_o = elem_a & opb_q;
            OP_XOR:  out_data_o = elem_a ^ opb_q;
            default: out_data_o = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (xfer) begin
            if (out_done_o) begin
                busy_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q    <= in_op_i;
            id_q    <= in_id_i;
            vaddr_q <= in_vaddr_i;
            elems_q <= in_elems_i;
            opa_q   <= in_opa_i;
            opb_q   <= in_opb_i;
        end
    end

    // the top level must never steer memory opcodes here
    a_no_mem_op: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        accept |=> (op_q != OP_LOAD) && (op_q != OP_STORE))
        else $error("alu unit holds a memory opcode");

endmodule

`default_nettype wire

/* verilog/vu_lsu_unit.sv */
// ========================================
// load/store unit with a small instruction queue,
// a data memory and one registered output beat
// ========================================

`timescale 1ns/1ps
`default_nettype none

module vu_lsu_unit (
    input  logic                        clk_i,
    input  logic                        async_rst_ni,

    input  logic                        in_valid_i,
    output logic                        in_ready_o,
    input  vu_pkg::op_e                 in_op_i,
    input  logic [vu_pkg::ID_W-1:0]     in_id_i,
    input  logic [vu_pkg::VADDR_W-1:0]  in_vaddr_i,
    input  logic [vu_pkg::ELEM_W-1:0]   in_elems_i,
    input  logic [vu_pkg::DATA_W-1:0]   in_opa_i,
    input  logic [vu_pkg::DATA_W-1:0]   in_opb_i,

    output logic                        out_valid_o,
    input  logic                        out_ready_i,
    output logic [vu_pkg::ID_W-1:0]     out_id_o,
    output logic [vu_pkg::VADDR_W-1:0]  out_vaddr_o,
    output logic [vu_pkg::DATA_W-1:0]   out_data_o,
    output logic                        out_store_o,
    output logic                        out_done_o,
    output logic                        lsu_empty_o
);
    import vu_pkg::*;

    // instruction queue
    op_e                q_op    [LSU_QUEUE_DEPTH];
    logic [ID_W-1:0]    q_id    [LSU_QUEUE_DEPTH];
    logic [VADDR_W-1:0] q_vaddr [LSU_QUEUE_DEPTH];
    logic [ELEM_W-1:0]  q_elems [LSU_QUEUE_DEPTH];
    logic [DATA_W-1:0]  q_opa   [LSU_QUEUE_DEPTH];
    logic [DATA_W-1:0]  q_opb   [LSU_QUEUE_DEPTH];

    logic [$clog2(LSU_QUEUE_DEPTH)-1:0]   wr_ptr_q, rd_ptr_q;
    logic [$clog2(LSU_QUEUE_DEPTH+1)-1:0] count_q;
    logic [ELEM_W-1:0]                    cnt_q;

    logic [DATA_W-1:0]     mem_q [MEM_DEPTH];
    logic [MEM_ADDR_W-1:0] addr;
    logic                  is_store;
    logic                  last;
    logic                  push, pop, adv;

    logic               out_valid_q;
    logic [ID_W-1:0]    out_id_q;
    logic [VADDR_W-1:0] out_vaddr_q;
    logic [DATA_W-1:0]  out_data_q;
    logic               out_store_q;
    logic               out_done_q;

    assign in_ready_o = (count_q < LSU_QUEUE_DEPTH);
    assign push       = in_valid_i && in_ready_o;

    assign is_store = (q_op[rd_ptr_q] == OP_STORE);
    assign last     = (cnt_q == q_elems[rd_ptr_q]);
    assign addr     = q_opa[rd_ptr_q][MEM_ADDR_W-1:0] + MEM_ADDR_W'(cnt_q);

    // one element per cycle unless the output register is stuck
    assign adv = (count_q != 0) && (!out_valid_q || out_ready_i);
    assign pop = adv && last;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
                cnt_q    <= '0;
            end else if (adv) begin
                cnt_q <= cnt_q + 1'b1;
            end
            count_q <= count_q + push - pop;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            q_op[wr_ptr_q]    <= in_op_i;
            q_id[wr_ptr_q]    <= in_id_i;
            q_vaddr[wr_ptr_q] <= in_vaddr_i;
            q_elems[wr_ptr_q] <= in_elems_i;
            q_opa[wr_ptr_q]   <= in_opa_i;
            q_opb[wr_ptr_q]   <= in_opb_i;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (adv && is_store) begin
            mem_q[addr] <= q_opb[rd_ptr_q] + DATA_W'(cnt_q);
        end
    end

    // a store only produces a beat after its last write
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            out_valid_q <= 1'b0;
        end else if (adv) begin
            out_valid_q <= !is_store || last;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    // registered memory read lands straight in the output register
    always_ff @(posedge clk_i) begin
        if (adv) begin
            out_id_q    <= q_id[rd_ptr_q];
            out_vaddr_q <= q_vaddr[rd_ptr_q];
            out_data_q  <= is_store ? '0 : mem_q[addr];
            out_store_q <= is_store;
            out_done_q  <= last;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_id_o    = out_id_q;
    assign out_vaddr_o = out_vaddr_q;
    assign out_data_o  = out_data_q;
    assign out_store_o = out_store_q;
    assign out_done_o  = out_done_q;
    assign lsu_empty_o = (count_q == 0) && !out_valid_q;

    // a push never lands on the slot of a live queue entry
    a_no_push_when_full: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        push |-> (count_q == 0) || (wr_ptr_q != rd_ptr_q))
        else $error("lsu queue accepted while full");

endmodule

`default_nettype wire

/* verilog/vu_result_arbiter.sv */
// ========================================
// sticky result arbiter, locks onto one unit
// until its done beat transfers, LSU first
// ========================================

`timescale 1ns/1ps
`default_nettype none

module vu_result_arbiter (
    input  logic                        clk_i,
    input  logic                        async_rst_ni,

    input  logic                        alu_valid_i,
    output logic                        alu_ready_o,
    input  logic [vu_pkg::ID_W-1:0]     alu_id_i,
    input  logic [vu_pkg::VADDR_W-1:0]  alu_vaddr_i,
    input  logic [vu_pkg::DATA_W-1:0]   alu_data_i,
    input  logic                        alu_done_i,

    input  logic                        lsu_valid_i,
    output logic                        lsu_ready_o,
    input  logic [vu_pkg::ID_W-1:0]     lsu_id_i,
    input  logic [vu_pkg::VADDR_W-1:0]  lsu_vaddr_i,
    input  logic [vu_pkg::DATA_W-1:0]   lsu_data_i,
    input  logic                        lsu_store_i,
    input  logic                        lsu_done_i,
    input  logic                        lsu_empty_i,

    output logic                        out_valid_o,
    input  logic                        out_ready_i,
    output logic [vu_pkg::ID_W-1:0]     out_id_o,
    output logic [vu_pkg::VADDR_W-1:0]  out_vaddr_o,
    output logic [vu_pkg::DATA_W-1:0]   out_data_o,
    output logic                        out_store_o,
    output logic                        out_done_o
);
    import vu_pkg::*;

    logic  lock_q;
    unit_e unit_q;
    logic  sel_valid;
    unit_e sel_unit;
    logic  done_xfer;

    always_comb begin
        sel_valid = 1'b0;
        sel_unit  = UNIT_ALU;
        if (lock_q) begin
            sel_valid = 1'b1;
            sel_unit  = unit_q;
        end else if (!lsu_empty_i) begin
            // lsu cannot stall, its data is guaranteed to arrive
            sel_valid = 1'b1;
            sel_unit  = UNIT_LSU;
        end else if (alu_valid_i) begin
            sel_valid = 1'b1;
            sel_unit  = UNIT_ALU;
        end
    end

    always_comb begin
        out_valid_o = 1'b0;
        out_id_o    = '0;
        out_vaddr_o = '0;
        out_data_o  = '0;
        out_store_o = 1'b0;
        out_done_o  = 1'b0;
        if (sel_valid && (sel_unit == UNIT_LSU)) begin
            out_valid_o = lsu_valid_i;
            out_id_o    = lsu_id_i;
            out_vaddr_o = lsu_vaddr_i;
            out_data_o  = lsu_data_i;
            out_store_o = lsu_store_i;
            out_done_o  = lsu_done_i;
        end else if (sel_valid) begin
            out_valid_o = alu_valid_i;
            out_id_o    = alu_id_i;
            out_vaddr_o = alu_vaddr_i;
            out_data_o  = alu_data_i;
            out_done_o  = alu_done_i;
        end
    end

    // ready only reaches the chosen unit
    assign alu_ready_o = sel_valid && (sel_unit == UNIT_ALU) && out_ready_i;
    assign lsu_ready_o = sel_valid && (sel_unit == UNIT_LSU) && out_ready_i;

    assign done_xfer = out_valid_o && out_ready_i && out_done_o;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            lock_q <= 1'b0;
            unit_q <= UNIT_ALU;
        end else begin
            lock_q <= sel_valid && !done_xfer;
            unit_q <= sel_unit;
        end
    end

    a_out_stable: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_id_o) &&
            $stable(out_vaddr_o) && $stable(out_data_o) && $stable(out_store_o) &&
            $stable(out_done_o))
        else $error("result beat changed while stalled");

endmodule

`default_nettype wire

/* verilog/vu_exec_cluster.sv */
// ========================================
// vector execution cluster top level, steers
// instructions to the ALU and LSU and merges results
// ========================================

`timescale 1ns/1ps
`default_nettype none

module vu_exec_cluster (
    input  logic                        clk_i,
    input  logic                        async_rst_ni,

    input  logic                        in_valid_i,
    output logic                        in_ready_o,
    input  vu_pkg::unit_e               in_unit_i,
    input  vu_pkg::op_e                 in_op_i,
    input  logic [vu_pkg::ID_W-1:0]     in_id_i,
    input  logic [vu_pkg::VADDR_W-1:0]  in_vaddr_i,
    input  logic [vu_pkg::ELEM_W-1:0]   in_elems_i,
    input  logic [vu_pkg::DATA_W-1:0]   in_opa_i,
    input  logic [vu_pkg::DATA_W-1:0]   in_opb_i,

    output logic                        out_valid_o,
    input  logic                        out_ready_i,
    output logic [vu_pkg::ID_W-1:0]     out_id_o,
    output logic [vu_pkg::VADDR_W-1:0]  out_vaddr_o,
    output logic [vu_pkg::DATA_W-1:0]   out_data_o,
    output logic                        out_store_o,
    output logic                        out_done_o
);
    import vu_pkg::*;

    logic               alu_in_valid, alu_in_ready;
    logic               lsu_in_valid, lsu_in_ready;

    logic               alu_valid, alu_ready, alu_done;
    logic [ID_W-1:0]    alu_id;
    logic [VADDR_W-1:0] alu_vaddr;
    logic [DATA_W-1:0]  alu_data;

    logic               lsu_valid, lsu_ready, lsu_done, lsu_store, lsu_empty;
    logic [ID_W-1:0]    lsu_id;
    logic [VADDR_W-1:0] lsu_vaddr;
    logic [DATA_W-1:0]  lsu_data;

    // only the targeted unit sees a valid, ready when nothing is offered
    assign alu_in_valid = in_valid_i && (in_unit_i == UNIT_ALU);
    assign lsu_in_valid = in_valid_i && (in_unit_i == UNIT_LSU);
    assign in_ready_o   = !in_valid_i || ((in_unit_i == UNIT_LSU) ? lsu_in_ready : alu_in_ready);

    vu_alu_unit u_alu (
        .clk_i        ( clk_i        ),
        .async_rst_ni ( async_rst_ni ),
        .in_valid_i   ( alu_in_valid ),
        .in_ready_o   ( alu_in_ready ),
        .in_op_i      ( in_op_i      ),
        .in_id_i      ( in_id_i      ),
        .in_vaddr_i   ( in_vaddr_i   ),
        .in_elems_i   ( in_elems_i   ),
        .in_opa_i     ( in_opa_i     ),
        .in_opb_i     ( in_opb_i     ),
        .out_valid_o  ( alu_valid    ),
        .out_ready_i  ( alu_ready    ),
        .out_id_o     ( alu_id       ),
        .out_vaddr_o  ( alu_vaddr    ),
        .out_data_o   ( alu_data     ),
        .out_done_o   ( alu_done     )
    );

    vu_lsu_unit u_lsu (
        .clk_i        ( clk_i        ),
        .async_rst_ni ( async_rst_ni ),
        .in_valid_i   ( lsu_in_valid ),
        .in_ready_o   ( lsu_in_ready ),
        .in_op_i      ( in_op_i      ),
        .in_id_i      ( in_id_i      ),
        .in_vaddr_i   ( in_vaddr_i   ),
        .in_elems_i   ( in_elems_i   ),
        .in_opa_i     ( in_opa_i     ),
        .in_opb_i     ( in_opb_i     ),
        .out_valid_o  ( lsu_valid    ),
        .out_ready_i  ( lsu_ready    ),
        .out_id_o     ( lsu_id       ),
        .out_vaddr_o  ( lsu_vaddr    ),
        .out_data_o   ( lsu_data     ),
        .out_store_o  ( lsu_store    ),
        .out_done_o   ( lsu_done     ),
        .lsu_empty_o  ( lsu_empty    )
    );

    vu_result_arbiter u_arbiter (
        .clk_i        ( clk_i        ),
        .async_rst_ni ( async_rst_ni ),
        .alu_valid_i  ( alu_valid    ),
        .alu_ready_o  ( alu_ready    ),
        .alu_id_i     ( alu_id       ),
        .alu_vaddr_i  ( alu_vaddr    ),
        .alu_data_i   ( alu_data     ),
        .alu_done_i   ( alu_done     ),
        .lsu_valid_i  ( lsu_valid    ),
        .lsu_ready_o  ( lsu_ready    ),
        .lsu_id_i     ( lsu_id       ),
        .lsu_vaddr_i  ( lsu_vaddr    ),
        .lsu_data_i   ( lsu_data     ),
        .lsu_store_i  ( lsu_store    ),
        .lsu_done_i   ( lsu_done     ),
        .lsu_empty_i  ( lsu_empty    ),
        .out_valid_o  ( out_valid_o  ),
        .out_ready_i  ( out_ready_i  ),
        .out_id_o     ( out_id_o     ),
        .out_vaddr_o  ( out_vaddr_o  ),
        .out_data_o   ( out_data_o   ),
        .out_store_o  ( out_store_o  ),
        .out_done_o   ( out_done_o   )
    );

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
// ========================================
// testbench clock, 20 ns period, and an active
// low reset held for the first three cycles
// ========================================

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic async_rst_no
);
    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        async_rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        async_rst_no <= 1'b1;
    end

endmodule

`default_nettype wire

/* sim/tb_vu_exec_cluster.sv */
// ========================================
// testbench for the vector execution cluster, directed
// and random instructions checked against a reference model
// ========================================

`timescale 1ns/1ps
`default_nettype none

module tb_vu_exec_cluster;
    import vu_pkg::*;

    localparam int NUM_DIRECTED    = 4 * 8 + 4;
    localparam int NUM_RANDOM      = 48;
    localparam int NUM_INSTR       = NUM_DIRECTED + NUM_RANDOM;
    localparam int WATCHDOG_CYCLES = 40 * NUM_INSTR + 200;
    localparam int BEAT_W          = ID_W + VADDR_W + DATA_W + 2;

    logic               clk_i;
    logic               async_rst_ni;
    logic               in_valid_i;
    logic               in_ready_o;
    unit_e              in_unit_i;
    op_e                in_op_i;
    logic [ID_W-1:0]    in_id_i;
    logic [VADDR_W-1:0] in_vaddr_i;
    logic [ELEM_W-1:0]  in_elems_i;
    logic [DATA_W-1:0]  in_opa_i;
    logic [DATA_W-1:0]  in_opb_i;
    logic               out_valid_o;
    logic               out_ready_i;
    logic [ID_W-1:0]    out_id_o;
    logic [VADDR_W-1:0] out_vaddr_o;
    logic [DATA_W-1:0]  out_data_o;
    logic               out_store_o;
    logic               out_done_o;

    integer          seed    = 62046;
    int              errors  = 0;
    int              issued  = 0;
    logic [ID_W-2:0] alu_seq = '0;
    logic [ID_W-2:0] lsu_seq = '0;

    // reference model, id bit 0 names the unit
    logic [DATA_W-1:0] ref_mem [MEM_DEPTH];
    logic [BEAT_W-1:0] alu_q [$];
    logic [BEAT_W-1:0] lsu_q [$];
    int                alu_bar_q [$];
    int                lsu_acc_cnt  = 0;
    int                lsu_done_cnt = 0;
    logic              prev_load    = 1'b0;
    logic              mid_valid    = 1'b0;
    logic [ID_W-1:0]   mid_id       = '0;

    logic              alu_hd_valid = 1'b0;
    logic              lsu_hd_valid = 1'b0;
    logic [BEAT_W-1:0] alu_hd       = '0;
    logic [BEAT_W-1:0] lsu_hd       = '0;
    int                alu_hd_bar   = 0;

    logic               exp_valid;
    logic [ID_W-1:0]    exp_id;
    logic [VADDR_W-1:0] exp_vaddr;
    logic [DATA_W-1:0]  exp_data;
    logic               exp_store;
    logic               exp_done;

    unit_e             r_unit  [NUM_RANDOM];
    op_e               r_op    [NUM_RANDOM];
    logic [ELEM_W-1:0] r_elems [NUM_RANDOM];
    logic [DATA_W-1:0] r_opa   [NUM_RANDOM];
    logic [DATA_W-1:0] r_opb   [NUM_RANDOM];
    logic              r_gap   [NUM_RANDOM];

    tb_clock_gen u_clk (
        .clk_o        ( clk_i        ),
        .async_rst_no ( async_rst_ni )
    );

    vu_exec_cluster uut (
        .clk_i        ( clk_i        ),
        .async_rst_ni ( async_rst_ni ),
        .in_valid_i   ( in_valid_i   ),
        .in_ready_o   ( in_ready_o   ),
        .in_unit_i    ( in_unit_i    ),
        .in_op_i      ( in_op_i      ),
        .in_id_i      ( in_id_i      ),
        .in_vaddr_i   ( in_vaddr_i   ),
        .in_elems_i   ( in_elems_i   ),
        .in_opa_i     ( in_opa_i     ),
        .in_opb_i     ( in_opb_i     ),
        .out_valid_o  ( out_valid_o  ),
        .out_ready_i  ( out_ready_i  ),
        .out_id_o     ( out_id_o     ),
        .out_vaddr_o  ( out_vaddr_o  ),
        .out_data_o   ( out_data_o   ),
        .out_store_o  ( out_store_o  ),
        .out_done_o   ( out_done_o   )
    );

    function automatic logic [BEAT_W-1:0] pack_beat(logic [ID_W-1:0] id,
        logic [VADDR_W-1:0] vaddr, logic [DATA_W-1:0] data, logic store, logic done);
        return {id, vaddr, data, store, done};
    endfunction

    // element k applies the opcode to opa plus k and opb
    function automatic logic [DATA_W-1:0] alu_elem(op_e op, logic [DATA_W-1:0] a,
        logic [DATA_W-1:0] b, int k);
        logic [DATA_W-1:0] ak;
        ak = a + k;
        case (op)
            OP_ADD:  return ak + b;
            OP_SUB:  return ak - b;
            OP_AND:  return ak & b;
            default: return ak ^ b;
        endcase
    endfunction

    assign exp_valid = out_id_o[0] ? lsu_hd_valid : alu_hd_valid;
    assign {exp_id, exp_vaddr, exp_data, exp_store, exp_done} = out_id_o[0] ? lsu_hd : alu_hd;

    // falling edge sees what the next rising edge transfers
    always @(negedge clk_i) begin : model_update
        int k;
        int idx;
        logic [DATA_W-1:0] ea;
        if (async_rst_ni) begin
            if (out_valid_o && out_ready_i) begin
                if (out_id_o[0] && lsu_q.size() > 0) begin
                    void'(lsu_q.pop_front());
                    if (out_done_o) begin
                        lsu_done_cnt++;
                    end
                end else if (!out_id_o[0] && alu_q.size() > 0) begin
                    void'(alu_q.pop_front());
                    void'(alu_bar_q.pop_front());
                end
                mid_valid = !out_done_o;
                mid_id    = out_id_o;
            end
            if (in_valid_i && in_ready_o) begin
                if (in_unit_i == UNIT_ALU) begin
                    for (k = 0; k <= in_elems_i; k++) begin
                        alu_q.push_back(pack_beat(in_id_i, in_vaddr_i,
                            alu_elem(in_op_i, in_opa_i, in_opb_i, k), 1'b0, k == in_elems_i));
                        alu_bar_q.push_back(prev_load ? lsu_acc_cnt : 0);
                    end
                end else begin
                    lsu_acc_cnt++;
                    for (k = 0; k <= in_elems_i; k++) begin
                        ea  = in_opa_i + k;
                        idx = int'(ea % MEM_DEPTH);
                        if (in_op_i == OP_STORE) begin
                            ref_mem[idx] = in_opb_i + k;
                        end else begin
                            lsu_q.push_back(pack_beat(in_id_i, in_vaddr_i, ref_mem[idx],
                                1'b0, k == in_elems_i));
                        end
                    end
                    if (in_op_i == OP_STORE) begin
                        lsu_q.push_back(pack_beat(in_id_i, in_vaddr_i, '0, 1'b1, 1'b1));
                    end
                end
            end
            prev_load = in_valid_i && in_ready_o && (in_unit_i == UNIT_LSU) &&
                (in_op_i == OP_LOAD);
            alu_hd_valid = (alu_q.size() > 0);
            lsu_hd_valid = (lsu_q.size() > 0);
            if (alu_hd_valid) begin
                alu_hd     = alu_q[0];
                alu_hd_bar = alu_bar_q[0];
            end
            if (lsu_hd_valid) begin
                lsu_hd = lsu_q[0];
            end
        end
    end

    a_reset_state: assert property (@(negedge clk_i)
        $rose(async_rst_ni) |-> !out_valid_o && in_ready_o)
        else begin
            errors++;
            $display("FAILED out_valid_o=%h in_ready_o=%h after reset",
                $sampled(out_valid_o), $sampled(in_ready_o));
        end

    a_beat_known: assert property (@(negedge clk_i) disable iff (!async_rst_ni)
        out_valid_o |-> exp_valid)
        else begin
            errors++;
            $display("result beat with id %h belongs to no outstanding instruction",
                $sampled(out_id_o));
        end

    a_data: assert property (@(negedge clk_i) disable iff (!async_rst_ni)
        out_valid_o && exp_valid |-> out_data_o == exp_data)
        else begin
            errors++;
            $display("FAILED out_data_o got %h expected %h",
                $sampled(out_data_o), $sampled(exp_data));
        end

    a_id_vaddr: assert property (@(negedge clk_i) disable iff (!async_rst_ni)
        out_valid_o && exp_valid |-> out_id_o == exp_id && out_vaddr_o == exp_vaddr)
        else begin
            errors++;
            $display("FAILED out_id_o/out_vaddr_o got %h/%h expected %h/%h",
                $sampled(out_id_o), $sampled(out_vaddr_o),
                $sampled(exp_id), $sampled(exp_vaddr));
        end

    a_flags: assert property (@(negedge clk_i) disable iff (!async_rst_ni)
        out_valid_o && exp_valid |-> out_done_o == exp_done && out_store_o == exp_store)
        else begin
            errors++;
            $display("FAILED out_done_o/out_store_o got %h/%h expected %h/%h",
                $sampled(out_done_o), $sampled(out_store_o),
                $sampled(exp_done), $sampled(exp_store));
        end

    a_contiguous: assert property (@(negedge clk_i) disable iff (!async_rst_ni)
        out_valid_o && mid_valid |-> out_id_o == mid_id)
        else begin
            errors++;
            $display("FAILED out_id_o got %h inside instruction %h",
                $sampled(out_id_o), $sampled(mid_id));
        end

    a_load_first: assert property (@(negedge clk_i) disable iff (!async_rst_ni)
        out_valid_o && !out_id_o[0] |-> lsu_done_cnt >= alu_hd_bar)
        else begin
            errors++;
            $display("arithmetic beat id %h overtook a load accepted just before it",
                $sampled(out_id_o));
        end

    a_stall_hold: assert property (@(negedge clk_i) disable iff (!async_rst_ni)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_id_o) &&
            $stable(out_vaddr_o) && $stable(out_data_o) && $stable(out_store_o) &&
            $stable(out_done_o))
        else begin
            errors++;
            $display("result beat changed or vanished while out_ready_i was low");
        end

    task automatic issue(unit_e unit, op_e op, logic [ELEM_W-1:0] elems,
        logic [DATA_W-1:0] opa, logic [DATA_W-1:0] opb);
        logic [ID_W-1:0] id;
        if (unit == UNIT_ALU) begin
            id      = {alu_seq, 1'b0};
            alu_seq = alu_seq + 1'b1;
        end else begin
            id      = {lsu_seq, 1'b1};
            lsu_seq = lsu_seq + 1'b1;
        end
        in_valid_i <= 1'b1;
        in_unit_i  <= unit;
        in_op_i    <= op;
        in_id_i    <= id;
        in_vaddr_i <= VADDR_W'(issued);
        in_elems_i <= elems;
        in_opa_i   <= opa;
        in_opb_i   <= opb;
        issued++;
        do begin
            @(negedge clk_i);
        end while (!in_ready_o);
        @(posedge clk_i);
    endtask

    task automatic idle(int cycles);
        in_valid_i <= 1'b0;
        repeat (cycles) @(posedge clk_i);
    endtask

    task automatic drain();
        in_valid_i <= 1'b0;
        while (alu_q.size() != 0 || lsu_q.size() != 0) begin
            @(posedge clk_i);
        end
    endtask

    initial begin
        out_ready_i = 1'b1;
        wait (async_rst_ni == 1'b1);
        forever begin
            @(posedge clk_i);
            out_ready_i <= ($random(seed) & 3) != 0;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("timeout after %0d cycles, results stopped arriving", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        int i;
        int e;
        in_valid_i = 1'b0;
        in_unit_i  = UNIT_ALU;
        in_op_i    = OP_ADD;
        in_id_i    = '0;
        in_vaddr_i = '0;
        in_elems_i = '0;
        in_opa_i   = '0;
        in_opb_i   = '0;
        for (i = 0; i < MEM_DEPTH; i++) begin
            ref_mem[i] = '0;
        end
        for (i = 0; i < NUM_RANDOM; i++) begin
            r_unit[i] = ($random(seed) & 1) ? UNIT_LSU : UNIT_ALU;
            if (r_unit[i] == UNIT_ALU) begin
                r_op[i] = op_e'(3'($random(seed) & 3));
            end else begin
                r_op[i] = ($random(seed) & 1) ? OP_STORE : OP_LOAD;
            end
            r_elems[i] = ELEM_W'($random(seed));
            r_opa[i]   = $random(seed);
            r_opb[i]   = $random(seed);
            r_gap[i]   = ($random(seed) & 7) == 0;
        end
        // first instruction is offered on the edge that releases reset
        wait (async_rst_ni == 1'b1);

        // every arithmetic opcode with every element count
        for (i = 0; i < 4; i++) begin
            for (e = 0; e < 8; e++) begin
                issue(UNIT_ALU, op_e'(3'(i)), ELEM_W'(e), 32'hffff_fffa + e,
                    32'h0f0f_3c3c + (i << 12));
            end
        end
        drain();

        // store then load, overlapping and wrapping addresses
        issue(UNIT_LSU, OP_STORE, 3'd7, 32'd14, 32'h0000_0100);
        issue(UNIT_LSU, OP_LOAD, 3'd7, 32'd18, 32'h0);
        drain();

        issue(UNIT_LSU, OP_LOAD, 3'd3, 32'd13, 32'h0);
        issue(UNIT_ALU, OP_XOR, 3'd5, 32'h1234_5678, 32'h00ff_00ff);
        drain();

        for (i = 0; i < NUM_RANDOM; i++) begin
            issue(r_unit[i], r_op[i], r_elems[i], r_opa[i], r_opb[i]);
            if (r_gap[i]) begin
                idle(2);
            end
        end
        drain();
        idle(4);

        $display("%0d instructions issued, %0d errors", issued, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
verilog/vu_pkg.sv
verilog/vu_alu_unit.sv
verilog/vu_lsu_unit.sv
verilog/vu_result_arbiter.sv
verilog/vu_exec_cluster.sv
sim/tb_clock_gen.sv
sim/tb_vu_exec_cluster.sv

/* Makefile */
TOP = tb_vu_exec_cluster

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
